// ==== common/synth_settings.svh ====
// Synth voice settings
// Channel, ramp shape, period width and multiplier depth
`ifndef SYNTH_SETTINGS_SVH
`define SYNTH_SETTINGS_SVH

// --------------------------------------------------
// MIDI
// --------------------------------------------------

// Channel the voice listens to, zero based
`define SYNTH_MIDI_CHANNEL 0

// --------------------------------------------------
// Voice shape and datapath
// --------------------------------------------------

// Samples per ramp, each a quarter of full scale
`define SYNTH_RAMP_STEPS 4

// Hold length width in sample ticks
`define SYNTH_PERIOD_W 12

// Register stages from operands to sample
`define SYNTH_MAC_LATENCY 3

`endif

// ==== common/midi_pkg.sv ====
// MIDI message types
// Byte, data, channel and command encodings shared by the parser and voice
`default_nettype none

package midi_pkg;

    typedef logic [7:0] midi_byte_t;
    typedef logic [6:0] midi_data_t;
    typedef logic [3:0] midi_chan_t;

    // High nibble of a channel status byte
    typedef enum logic [3:0] {
        CMD_NOTE_OFF    = 4'h8,
        CMD_NOTE_ON     = 4'h9,
        CMD_POLY_PRESS  = 4'hA,
        CMD_CTRL_CHANGE = 4'hB,
        // Only these two carry a single data byte
        CMD_PROG_CHANGE = 4'hC,
        CMD_CHAN_PRESS  = 4'hD,
        CMD_PITCH_BEND  = 4'hE
    } midi_cmd_t;

endpackage

`default_nettype wire

// ==== common/dsp_pkg.sv ====
// DSP datapath types
// Sample, amplitude, coefficient, product and hold period widths
`default_nettype none

`include "synth_settings.svh"

package dsp_pkg;

    typedef logic signed [17:0] sample_t;
    // Velocity times 1024
    typedef logic signed [17:0] amp_t;
    // Q2.16, full scale is 65536
    typedef logic signed [17:0] coef_t;
    typedef logic signed [35:0] prod_t;
    // Hold length in sample ticks
    typedef logic [`SYNTH_PERIOD_W-1:0] period_t;

endpackage

`default_nettype wire

// ==== rtl/midi_parser.sv ====
// MIDI byte parser
// Assembles raw bytes into channel messages, keeps running status,
// drops data after system bytes and skips real-time bytes
`timescale 1ns/10ps
`default_nettype none

module midi_parser
    import midi_pkg::*;
(
    input  wire             i_reset,
    input  wire             i_clk,
    input  wire             i_byte_vld,
    input  wire midi_byte_t i_byte,
    output logic            o_msg_vld,
    output midi_cmd_t       o_msg_cmd,
    output midi_chan_t      o_msg_chan,
    output midi_data_t      o_msg_data0,
    output midi_data_t      o_msg_data1
);

    typedef enum logic [1:0] {NO_STATUS, WAIT_D0, WAIT_D1} parse_state_t;

    parse_state_t state;
    midi_cmd_t    run_cmd;
    midi_chan_t   run_chan;
    midi_data_t   data0_r;
    logic         is_realtime;
    logic         is_system;
    logic         is_data;
    logic         one_data;

    // Byte classes
    assign is_realtime = i_byte >= 8'hF8;
    assign is_system   = i_byte[7:4] == 4'hF;
    assign is_data     = !i_byte[7];
    assign one_data    = (run_cmd == CMD_PROG_CHANGE) || (run_cmd == CMD_CHAN_PRESS);

    // --------------------------------------------------
    // Status and message strobe
    // --------------------------------------------------
    always_ff @(posedge i_reset or posedge i_clk) begin
        if (i_clk) begin
            state     <= NO_STATUS;
            run_cmd   <= CMD_NOTE_OFF;
            run_chan  <= '0;
            o_msg_vld <= 1'b0;
        end else begin
            o_msg_vld <= 1'b0;
            if (i_byte_vld && !is_realtime) begin
                if (is_system) begin
                    state <= NO_STATUS;
                end else if (!is_data) begin
                    run_cmd  <= midi_cmd_t'(i_byte[7:4]);
                    run_chan <= i_byte[3:0];
                    state    <= WAIT_D0;
                end else begin
                    case (state)
                        WAIT_D0: begin
                            if (one_data) begin
                                o_msg_vld <= 1'b1;
                            end else begin
                                state <= WAIT_D1;
                            end
                        end
                        WAIT_D1: begin
                            o_msg_vld <= 1'b1;
                            state     <= WAIT_D0;
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // Message payload
    always_ff @(posedge i_reset) begin
        if (i_byte_vld && is_data) begin
            o_msg_cmd  <= run_cmd;
            o_msg_chan <= run_chan;
            if (state == WAIT_D0) begin
                data0_r     <= i_byte[6:0];
                o_msg_data0 <= i_byte[6:0];
                o_msg_data1 <= '0;
            end else if (state == WAIT_D1) begin
                o_msg_data0 <= data0_r;
                o_msg_data1 <= i_byte[6:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== pulse_gen/note_period_rom.sv ====
// Note period lookup
// Hold length in sample ticks for a MIDI note: octave-0 half period
// at 48 kHz, shifted down by the octave, never below one
`timescale 1ns/10ps
`default_nettype none

module note_period_rom
    import midi_pkg::*;
    import dsp_pkg::*;
(
    input  wire midi_data_t i_note,
    output period_t         o_period
);

    logic [6:0] rem;
    logic [3:0] octave;
    period_t    base;
    period_t    shifted;

    always_comb begin
        // Note div 12 over the ten full octaves
        rem    = i_note;
        octave = '0;
        for (int i = 0; i < 10; i++) begin
            if (rem >= 7'd12) begin
                rem    = rem - 7'd12;
                octave = octave + 4'd1;
            end
        end

        case (rem[3:0])
            4'd0:    base = 12'd2935;
            4'd1:    base = 12'd2771;
            4'd2:    base = 12'd2615;
            4'd3:    base = 12'd2468;
            4'd4:    base = 12'd2330;
            4'd5:    base = 12'd2199;
            4'd6:    base = 12'd2076;
            4'd7:    base = 12'd1959;
            4'd8:    base = 12'd1849;
            4'd9:    base = 12'd1745;
            4'd10:   base = 12'd1647;
            default: base = 12'd1555;
        endcase

        shifted  = base >> octave;
        o_period = (shifted == '0) ? period_t'(1) : shifted;
    end

endmodule

`default_nettype wire

// ==== pulse_gen/pulse_sequencer.sv ====
// Pulse voice sequencer
// Tracks the held note and steps a shaped square wave, one multiply
// per sample tick: ramp up, hold, ramp down, then the negative mirror
`timescale 1ns/10ps
`default_nettype none

`include "synth_settings.svh"

module pulse_sequencer
    import midi_pkg::*;
    import dsp_pkg::*;
(
    input  wire             i_reset,
    input  wire             i_clk,
    input  wire             i_msg_vld,
    input  wire midi_cmd_t  i_msg_cmd,
    input  wire midi_chan_t i_msg_chan,
    input  wire midi_data_t i_msg_data0,
    input  wire midi_data_t i_msg_data1,
    input  wire             i_sample_tick,
    input  wire period_t    i_period,
    output midi_data_t      o_note,
    output logic            o_mac_vld,
    output amp_t            o_mac_amp,
    output coef_t           o_mac_coef
);

    typedef enum logic [2:0] {
        IDLE,
        RAMP_UP,
        HOLD_POS,
        RAMP_DOWN,
        RAMP_NEG,
        HOLD_NEG,
        RAMP_BACK
    } voice_state_t;

    localparam logic [2:0] RAMP_LAST = 3'(`SYNTH_RAMP_STEPS);

    voice_state_t state;
    logic [2:0]   ramp_idx;
    period_t      hold_cnt;
    period_t      period_r;
    amp_t         amp_r;
    amp_t         vel_amp;
    amp_t         amp_nxt;
    logic         held;
    midi_data_t   note_r;
    midi_data_t   vel_r;
    logic         chan_hit;
    logic         note_on_ev;
    logic         note_off_ev;
    logic [2:0]   issue_idx;
    logic         neg_half;
    logic         issue;
    coef_t        coef_mag;
    coef_t        coef_nxt;

    // --------------------------------------------------
    // Note state
    // --------------------------------------------------
    assign chan_hit    = i_msg_vld && (i_msg_chan == midi_chan_t'(`SYNTH_MIDI_CHANNEL));
    assign note_on_ev  = chan_hit && (i_msg_cmd == CMD_NOTE_ON) && (i_msg_data1 != '0);
    // Velocity 0 note on is a note off
    assign note_off_ev = chan_hit && ((i_msg_cmd == CMD_NOTE_OFF) ||
                         ((i_msg_cmd == CMD_NOTE_ON) && (i_msg_data1 == '0)));

    always_ff @(posedge i_reset or posedge i_clk) begin
        if (i_clk) begin
            held   <= 1'b0;
            note_r <= '0;
            vel_r  <= '0;
        end else if (note_on_ev) begin
            held   <= 1'b1;
            note_r <= i_msg_data0;
            vel_r  <= i_msg_data1;
        end else if (note_off_ev && (i_msg_data0 == note_r)) begin
            held <= 1'b0;
        end
    end

    assign o_note = note_r;

    // --------------------------------------------------
    // Operand select
    // --------------------------------------------------
    always_comb begin
        vel_amp   = {1'b0, vel_r, 10'd0};
        issue     = i_sample_tick && ((state != IDLE) || held);
        // IDLE issues the first ramp step with the fresh amplitude
        issue_idx = (state == IDLE) ? 3'd1 : ramp_idx;
        amp_nxt   = (state == IDLE) ? vel_amp : amp_r;
        neg_half  = (state == RAMP_NEG) || (state == HOLD_NEG) || (state == RAMP_BACK);

        case (issue_idx)
            3'd0:    coef_mag = 18'sd0;
            3'd1:    coef_mag = 18'sd16384;
            3'd2:    coef_mag = 18'sd32768;
            3'd3:    coef_mag = 18'sd49152;
            default: coef_mag = 18'sd65536;
        endcase
        coef_nxt = neg_half ? -coef_mag : coef_mag;
    end

    // --------------------------------------------------
    // Voice FSM
    // --------------------------------------------------
    always_ff @(posedge i_reset or posedge i_clk) begin
        if (i_clk) begin
            state     <= IDLE;
            ramp_idx  <= '0;
            hold_cnt  <= '0;
            o_mac_vld <= 1'b0;
        end else begin
            o_mac_vld <= issue;
            if (issue) begin
                case (state)
                    IDLE: begin
                        state    <= RAMP_UP;
                        ramp_idx <= 3'd2;
                    end
                    RAMP_UP, RAMP_NEG: begin
                        if (ramp_idx == RAMP_LAST) begin
                            state    <= (state == RAMP_UP) ? HOLD_POS : HOLD_NEG;
                            hold_cnt <= period_r;
                        end else begin
                            ramp_idx <= ramp_idx + 3'd1;
                        end
                    end
                    HOLD_POS, HOLD_NEG: begin
                        if (hold_cnt == period_t'(1)) begin
                            state    <= (state == HOLD_POS) ? RAMP_DOWN : RAMP_BACK;
                            ramp_idx <= RAMP_LAST - 3'd1;
                        end else begin
                            hold_cnt <= hold_cnt - period_t'(1);
                        end
                    end
                    RAMP_DOWN: begin
                        if (ramp_idx == '0) begin
                            state    <= RAMP_NEG;
                            ramp_idx <= 3'd1;
                        end else begin
                            ramp_idx <= ramp_idx - 3'd1;
                        end
                    end
                    RAMP_BACK: begin
                        if (ramp_idx == '0) begin
                            state <= IDLE;
                        end else begin
                            ramp_idx <= ramp_idx - 3'd1;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // Operands and per-cycle amplitude and period
    always_ff @(posedge i_reset) begin
        if (issue) begin
            o_mac_amp  <= amp_nxt;
            o_mac_coef <= coef_nxt;
            if (state == IDLE) begin
                amp_r    <= vel_amp;
                period_r <= i_period;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sample_mac.sv ====
// Pipelined sample multiplier
// Amplitude times Q2.16 coefficient, scaled back to an 18-bit sample
// Operands, product and sample each take one register stage
`timescale 1ns/10ps
`default_nettype none

`include "synth_settings.svh"

module sample_mac
    import dsp_pkg::*;
(
    input  wire        i_reset,
    input  wire        i_clk,
    input  wire        i_vld,
    input  wire amp_t  i_amp,
    input  wire coef_t i_coef,
    output logic       o_vld,
    output sample_t    o_sample
);

    localparam int LAT = `SYNTH_MAC_LATENCY;

    logic [LAT-1:0] vld_pipe;
    amp_t           amp_r;
    coef_t          coef_r;
    prod_t          prod_r;

    // Valid follows the data through every stage
    always_ff @(posedge i_reset or posedge i_clk) begin
        if (i_clk) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[LAT-2:0], i_vld};
        end
    end

    assign o_vld = vld_pipe[LAT-1];

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------
    always_ff @(posedge i_reset) begin
        // Stage 1
        amp_r    <= i_amp;
        coef_r   <= i_coef;
        // Stage 2
        prod_r   <= prod_t'(amp_r) * prod_t'(coef_r);
        // Stage 3, drop the Q2.16 fraction
        o_sample <= prod_r[33:16];
    end

endmodule

`default_nettype wire

// ==== rtl/synth_top.sv ====
// MIDI pulse synth top
// Parser feeds the voice sequencer, which drives the sample multiplier
`timescale 1ns/10ps
`default_nettype none

module synth_top
    import midi_pkg::*;
    import dsp_pkg::*;
(
    input  wire             i_reset,
    input  wire             i_clk,
    input  wire             i_midi_byte_vld,
    input  wire midi_byte_t i_midi_byte,
    input  wire             i_sample_tick,
    output logic            o_sample_vld,
    output sample_t         o_sample
);

    logic       msg_vld;
    midi_cmd_t  msg_cmd;
    midi_chan_t msg_chan;
    midi_data_t msg_data0;
    midi_data_t msg_data1;
    midi_data_t note;
    period_t    period;
    logic       mac_vld;
    amp_t       mac_amp;
    coef_t      mac_coef;

    midi_parser u_parser (
        .i_reset     (i_reset),
        .i_clk       (i_clk),
        .i_byte_vld  (i_midi_byte_vld),
        .i_byte      (i_midi_byte),
        .o_msg_vld   (msg_vld),
        .o_msg_cmd   (msg_cmd),
        .o_msg_chan  (msg_chan),
        .o_msg_data0 (msg_data0),
        .o_msg_data1 (msg_data1)
    );

    pulse_sequencer u_sequencer (
        .i_reset       (i_reset),
        .i_clk         (i_clk),
        .i_msg_vld     (msg_vld),
        .i_msg_cmd     (msg_cmd),
        .i_msg_chan    (msg_chan),
        .i_msg_data0   (msg_data0),
        .i_msg_data1   (msg_data1),
        .i_sample_tick (i_sample_tick),
        .i_period      (period),
        .o_note        (note),
        .o_mac_vld     (mac_vld),
        .o_mac_amp     (mac_amp),
        .o_mac_coef    (mac_coef)
    );

    note_period_rom u_period_rom (
        .i_note   (note),
        .o_period (period)
    );

    sample_mac u_mac (
        .i_reset  (i_reset),
        .i_clk    (i_clk),
        .i_vld    (mac_vld),
        .i_amp    (mac_amp),
        .i_coef   (mac_coef),
        .o_vld    (o_sample_vld),
        .o_sample (o_sample)
    );

endmodule

`default_nettype wire

// ==== test/tb_synth.sv ====
// Testbench for the MIDI pulse synth
// Table of MIDI bytes and tick counts, a reference model of the parser
// and voice, and a monitor that checks every output sample
`timescale 1ns/10ps
`default_nettype none

`include "synth_settings.svh"

module tb_synth
    import midi_pkg::*;
    import dsp_pkg::*;
();

    localparam int NUM_ROWS = 19;
    localparam logic [31:0] SEED = 32'h40a4_e0d6;
    // Tick driven on a rising edge, sample valid 4 clocks later, seen at the falling edge
    localparam int SAMPLE_DELAY = 4 * 8 + 4;

    typedef struct packed {
        logic [2:0]  n_bytes;
        logic [31:0] bytes;
        logic [7:0]  n_ticks;
        logic        add_f8;
    } stim_row_t;

    // DUT clock is on i_reset, DUT reset is on i_clk
    logic       clk;
    logic       rst;
    logic       midi_byte_vld;
    midi_byte_t midi_byte;
    logic       sample_tick;
    logic       o_sample_vld;
    sample_t    o_sample;

    stim_row_t  stim_table [NUM_ROWS];

    // Model state
    logic       m_have_status;
    logic       m_wait_d1;
    logic [3:0] m_cmd;
    logic [3:0] m_chan;
    logic [6:0] m_d0;
    logic       m_held;
    logic [6:0] m_note;
    logic [6:0] m_vel;
    int         pend_q [$];
    int         exp_q [$];
    int         sample_at_q [$];
    int         fail_count;
    int         discard;

    synth_top dut (
        .i_reset         (clk),
        .i_clk           (rst),
        .i_midi_byte_vld (midi_byte_vld),
        .i_midi_byte     (midi_byte),
        .i_sample_tick   (sample_tick),
        .o_sample_vld    (o_sample_vld),
        .o_sample        (o_sample)
    );

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic signed [31:0] got,
                               input logic signed [31:0] expected);
        if (got !== expected) begin
            fail_count++;
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, expected);
            $display("CHECKS FAILED");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic int note_period(input logic [6:0] note);
        int  octave;
        int  semi;
        real freq;
        int  base;
        int  hold;
        octave = int'(note) / 12;
        semi   = int'(note) % 12;
        // Octave-0 frequency, A4 at note 69 is 440 Hz
        freq   = 440.0 * (2.0 ** ((real'(semi) - 69.0) / 12.0));
        // Half period at 48 kHz
        base   = $rtoi(24000.0 / freq + 0.5);
        hold   = base >> octave;
        if (hold < 1) begin
            hold = 1;
        end
        return hold;
    endfunction

    task automatic apply_msg(input logic [3:0] cmd, input logic [3:0] chan,
                             input logic [6:0] d0, input logic [6:0] d1);
        if (chan == 4'(`SYNTH_MIDI_CHANNEL)) begin
            if ((cmd == CMD_NOTE_ON) && (d1 != 7'd0)) begin
                m_held = 1'b1;
                m_note = d0;
                m_vel  = d1;
            end else if (((cmd == CMD_NOTE_OFF) || (cmd == CMD_NOTE_ON)) && (d0 == m_note)) begin
                m_held = 1'b0;
            end
        end
    endtask

    task automatic model_byte(input logic [7:0] b);
        // Real-time bytes change nothing
        if (b < 8'hF8) begin
            if (b >= 8'hF0) begin
                m_have_status = 1'b0;
            end else if (b[7]) begin
                m_have_status = 1'b1;
                m_cmd         = b[7:4];
                m_chan        = b[3:0];
                m_wait_d1     = 1'b0;
            end else if (m_have_status) begin
                if (!m_wait_d1) begin
                    m_d0 = b[6:0];
                    if ((m_cmd == CMD_PROG_CHANGE) || (m_cmd == CMD_CHAN_PRESS)) begin
                        apply_msg(m_cmd, m_chan, b[6:0], 7'd0);
                    end else begin
                        m_wait_d1 = 1'b1;
                    end
                end else begin
                    apply_msg(m_cmd, m_chan, m_d0, b[6:0]);
                    m_wait_d1 = 1'b0;
                end
            end
        end
    endtask

    // One full wave cycle from the current note and velocity
    task automatic build_cycle();
        int amp;
        int hold;
        int steps;
        amp   = int'(m_vel) * 1024;
        hold  = note_period(m_note);
        steps = `SYNTH_RAMP_STEPS;
        for (int k = 1; k <= steps; k++) begin
            pend_q.push_back(amp * k / steps);
        end
        repeat (hold) pend_q.push_back(amp);
        for (int k = steps - 1; k >= 0; k--) begin
            pend_q.push_back(amp * k / steps);
        end
        for (int k = 1; k <= steps; k++) begin
            pend_q.push_back(-amp * k / steps);
        end
        repeat (hold) pend_q.push_back(-amp);
        for (int k = steps - 1; k >= 0; k--) begin
            pend_q.push_back(-amp * k / steps);
        end
    endtask

    task automatic model_tick();
        if ((pend_q.size() == 0) && m_held) begin
            build_cycle();
        end
        if (pend_q.size() != 0) begin
            exp_q.push_back(pend_q.pop_front());
            sample_at_q.push_back(int'($time) + SAMPLE_DELAY);
        end
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic load_table();
        stim_table[0]  = '{3'd0, 32'h0000_0000, 8'd6,  1'b0};
        stim_table[1]  = '{3'd3, 32'h9078_6400, 8'd40, 1'b0};
        stim_table[2]  = '{3'd3, 32'h8078_0000, 8'd5,  1'b0};
        stim_table[3]  = '{3'd3, 32'h907B_2000, 8'd10, 1'b0};
        // Note off for a note that is not held
        stim_table[4]  = '{3'd3, 32'h807C_0000, 8'd10, 1'b0};
        stim_table[5]  = '{3'd3, 32'h917B_0000, 8'd20, 1'b1};
        stim_table[6]  = '{3'd3, 32'h907B_0000, 8'd6,  1'b0};
        stim_table[7]  = '{3'd3, 32'h907F_7F00, 8'd9,  1'b1};
        // Running status note on with velocity 0, mid cycle
        stim_table[8]  = '{3'd2, 32'h7F00_0000, 8'd15, 1'b0};
        stim_table[9]  = '{3'd3, 32'h907A_5000, 8'd8,  1'b0};
        stim_table[10] = '{3'd2, 32'hC005_0000, 8'd6,  1'b1};
        stim_table[11] = '{3'd3, 32'hB007_6400, 8'd6,  1'b0};
        stim_table[12] = '{3'd3, 32'h9279_7F00, 8'd20, 1'b0};
        stim_table[13] = '{3'd3, 32'h907C_4000, 8'd7,  1'b0};
        // New note mid cycle takes effect at the next cycle start
        stim_table[14] = '{3'd2, 32'h7F10_0000, 8'd31, 1'b1};
        stim_table[15] = '{3'd2, 32'h7F00_0000, 8'd10, 1'b0};
        // System byte drops the data that follows
        stim_table[16] = '{3'd3, 32'hF67E_5000, 8'd6,  1'b0};
        stim_table[17] = '{3'd3, 32'h907E_5000, 8'd20, 1'b0};
        stim_table[18] = '{3'd3, 32'h807E_0000, 8'd4,  1'b0};
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge clk);
        midi_byte_vld <= 1'b1;
        midi_byte     <= b;
        model_byte(b);
        @(posedge clk);
        midi_byte_vld <= 1'b0;
    endtask

    task automatic apply_ticks(input int n);
        int gap;
        for (int t = 0; t < n; t++) begin
            gap = 2 + int'($urandom % 8);
            @(posedge clk);
            sample_tick <= 1'b1;
            model_tick();
            @(posedge clk);
            sample_tick <= 1'b0;
            repeat (gap - 2) @(posedge clk);
        end
    endtask

    task automatic run_row(input stim_row_t row);
        logic [7:0] b;
        for (int i = 0; i < int'(row.n_bytes); i++) begin
            b = row.bytes[31 - 8 * i -: 8];
            send_byte(b);
            if ((i == 0) && row.add_f8) begin
                send_byte(8'hF8);
            end
        end
        // Let the message reach the voice before ticking
        repeat (3) @(posedge clk);
        apply_ticks(int'(row.n_ticks));
    endtask

    // --------------------------------------------------
    // Monitor and watchdog
    // --------------------------------------------------
    always @(negedge clk) begin
        int exp_val;
        int exp_at;
        if (!rst && o_sample_vld) begin
            if (exp_q.size() == 0) begin
                fail_count++;
                $display("Sample at %0t arrived with no sample expected", $time);
                $display("CHECKS FAILED");
                $fatal(1, "Unexpected sample");
            end else begin
                exp_val = exp_q.pop_front();
                exp_at  = sample_at_q.pop_front();
                check_value("o_sample_vld time", int'($time), exp_at);
                check_value("o_sample", 32'(o_sample), exp_val);
            end
        end
    end

    initial begin
        int limit;
        #1;
        limit = 200;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += int'(stim_table[r].n_ticks) * 9 + 30;
        end
        repeat (limit) @(posedge clk);
        $display("Run did not finish within %0d cycles", limit);
        $display("CHECKS FAILED");
        $fatal(1, "Watchdog timeout");
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        midi_byte_vld = 1'b0;
        midi_byte     = '0;
        sample_tick   = 1'b0;
        m_have_status = 1'b0;
        m_wait_d1     = 1'b0;
        m_cmd         = '0;
        m_chan        = '0;
        m_d0          = '0;
        m_held        = 1'b0;
        m_note        = '0;
        m_vel         = '0;
        fail_count    = 0;
        discard       = $urandom(SEED);
        $timeformat(-9, 0, " ns", 0);
        load_table();

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(stim_table[r]);
        end

        // Room for the last samples still in the pipeline
        repeat (8) @(posedge clk);
        check_value("expected samples left", exp_q.size(), 0);

        if (fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/midi_pkg.sv
common/dsp_pkg.sv
rtl/midi_parser.sv
pulse_gen/note_period_rom.sv
pulse_gen/pulse_sequencer.sv
rtl/sample_mac.sv
rtl/synth_top.sv
test/tb_synth.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_synth -f project.f

sim:
	verilator --binary --timing --top-module tb_synth -f project.f -o tb_synth
	-./obj_dir/tb_synth > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "CHECKS FAILED" $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
